//--- logic/audio_mixer.sv
// Audio mixer
// Adds halved Journey PCM to the core audio with saturation,
// other games pass the unsigned core samples through

`timescale 1ns/100ps
`default_nettype none

module audio_mixer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  game_pkg::game_t      game,
	input  audio_pkg::sample_t   core_audio_l,
	input  audio_pkg::sample_t   core_audio_r,
	input  audio_pkg::sample_t   pcm,
	output audio_pkg::sample_t   audio_l,
	output audio_pkg::sample_t   audio_r,
	output logic                 audio_signed
);

	audio_pkg::mix_t pcm_half;
	audio_pkg::mix_t mix_l;
	audio_pkg::mix_t mix_r;
	logic            journey;

	// Clamp a 17-bit sum to the signed 16-bit range
	function automatic audio_pkg::sample_t saturate(input audio_pkg::mix_t sum);
		audio_pkg::sample_t result;
		if (sum > 17'sd32767)
			result = 16'h7fff;
		else if (sum < -17'sd32768)
			result = 16'h8000;
		else
			result = sum[15:0];
		return result;
	endfunction

	assign journey  = (game == game_pkg::JOURNEY);
	// Arithmetic halving keeps the PCM sign
	assign pcm_half = {{2{pcm[15]}}, pcm[15:1]};
	assign mix_l    = pcm_half + $signed({1'b0, core_audio_l});
	assign mix_r    = pcm_half + $signed({1'b0, core_audio_r});

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			audio_l      <= '0;
			audio_r      <= '0;
			audio_signed <= 1'b0;
		end else begin
			audio_signed <= journey;
			if (journey) begin
				audio_l <= saturate(mix_l);
				audio_r <= saturate(mix_r);
			end else begin
				audio_l <= core_audio_l;
				audio_r <= core_audio_r;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/audio_pkg.sv
// Audio sample and wave memory types

`default_nettype none

package audio_pkg;

	// One audio sample, signedness depends on the source
	typedef logic [15:0] sample_t;

	// Sum of halved PCM and unsigned core sample before clamping
	typedef logic signed [16:0] mix_t;

	// Wave memory read word
	typedef logic [63:0] mem_word_t;

endpackage

`default_nettype wire

//--- logic/download_ctrl.sv
// Download controller
// Decodes the host loader stream into ROM writes, game select and DIP banks,
// and generates the core reset with its delayed second pulse

`timescale 1ns/100ps
`default_nettype none

`include "mcr3_frontend_params.svh"

module download_ctrl (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  game_pkg::dl_index_t   ioctl_index,
	input  game_pkg::dl_addr_t    ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  status_reset,
	input  logic                  button_reset,
	output logic                  rom_wr,
	output logic                  rom_loaded,
	output logic                  wav_loaded,
	output logic                  core_reset,
	output game_pkg::game_t       game,
	output game_pkg::input_byte_t dip0,
	output logic                  service
);

	logic        rom_download;
	logic        wav_download;
	logic        rom_dl_q1;
	logic        rom_dl_q2;
	logic        wav_dl_q1;
	logic        wav_dl_q2;
	logic [7:0]  game_byte;
	logic [15:0] reset_count;
	logic        hold_reset;
	logic [7:0]  dip_bank [`MCR_DIP_BANKS];

	assign rom_download = ioctl_download && (ioctl_index == `MCR_DL_ROM);
	assign wav_download = ioctl_download && (ioctl_index == `MCR_DL_WAV);

	// CPU ROM occupies the first 64K of the image
	assign rom_wr = ioctl_wr && rom_download && (ioctl_addr < `MCR_CPU_ROM_LIMIT);

	// ============================================================
	// Game select and DIP banks
	// ============================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game_byte <= 8'd0;
			game      <= game_pkg::TAPPER;
		end else begin
			if (ioctl_wr && (ioctl_index == `MCR_DL_GAME))
				game_byte <= ioctl_dout;
			case (game_byte)
				8'd1:    game <= game_pkg::TIMBER;
				8'd2:    game <= game_pkg::DOTRON;
				8'd3:    game <= game_pkg::JOURNEY;
				default: game <= game_pkg::TAPPER;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && (ioctl_index == `MCR_DL_DIP) && (ioctl_addr < `MCR_DIP_BANKS))
			dip_bank[ioctl_addr[2:0]] <= ioctl_dout;
	end

	assign dip0    = dip_bank[0];
	// Service switch lives in bank 1
	assign service = dip_bank[1][0];

	// ============================================================
	// Download completion and core reset
	// ============================================================

	// Reload the delayed-reset counter while any reset source is active
	assign hold_reset = status_reset | button_reset | ~rom_loaded;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_dl_q1   <= 1'b0;
			rom_dl_q2   <= 1'b0;
			wav_dl_q1   <= 1'b0;
			wav_dl_q2   <= 1'b0;
			rom_loaded  <= 1'b0;
			wav_loaded  <= 1'b0;
			reset_count <= `MCR_RESET_HOLD;
			core_reset  <= 1'b1;
		end else begin
			rom_dl_q1 <= rom_download;
			rom_dl_q2 <= rom_dl_q1;
			wav_dl_q1 <= wav_download;
			wav_dl_q2 <= wav_dl_q1;

			// Falling edge of each download marks it complete
			if (rom_dl_q2 && !rom_dl_q1)
				rom_loaded <= 1'b1;
			if (wav_dl_q2 && !wav_dl_q1)
				wav_loaded <= 1'b1;

			if (hold_reset)
				reset_count <= `MCR_RESET_HOLD;
			else if (reset_count != 16'd0)
				reset_count <= reset_count - 16'd1;

			// Second reset pulse once the count reaches 1
			core_reset <= hold_reset | rom_download | (reset_count == 16'd1);
		end
	end

endmodule

`default_nettype wire

//--- logic/game_pkg.sv
// Game identity and control input types
// Shared by the loader, input mapping and audio selection

`default_nettype none

package game_pkg;

	// Supported cabinets, in game-select byte order
	typedef enum logic [1:0] {
		TAPPER  = 2'd0,
		TIMBER  = 2'd1,
		DOTRON  = 2'd2,
		JOURNEY = 2'd3
	} game_t;

	// Raw joystick word from the host
	typedef logic [31:0] joy_word_t;

	// Cabinet input byte, active low
	typedef logic [7:0] input_byte_t;

	// Absolute spinner position
	typedef logic [8:0] spin_pos_t;

	// Host loader stream fields
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;

endpackage

`default_nettype wire

//--- logic/input_mapper.sv
// Input mapper
// Merges both players' controls, picks the most recently moved spinner
// and builds the registered active-low input bytes of each game

`timescale 1ns/100ps
`default_nettype none

`include "mcr3_frontend_params.svh"

module input_mapper (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  game_pkg::joy_word_t   joy1,
	input  game_pkg::joy_word_t   joy2,
	input  game_pkg::spin_pos_t   sp1,
	input  game_pkg::spin_pos_t   sp2,
	input  game_pkg::game_t       game,
	input  game_pkg::input_byte_t dip0,
	input  logic                  service,
	output game_pkg::input_byte_t input_0,
	output game_pkg::input_byte_t input_1,
	output game_pkg::input_byte_t input_2,
	output game_pkg::input_byte_t input_3,
	output game_pkg::input_byte_t input_4,
	output logic                  landscape
);

	game_pkg::joy_word_t joy;
	game_pkg::spin_pos_t sp1_q;
	game_pkg::spin_pos_t sp2_q;
	game_pkg::spin_pos_t spin;
	logic                sp_sel;
	logic                m_right;
	logic                m_left;
	logic                m_down;
	logic                m_up;
	logic                m_fire_a;
	logic                m_fire_b;
	logic                m_fire_c;
	logic                m_fire_d;
	logic                m_start1;
	logic                m_start2;
	logic                m_coin;

	// Merged controls of both players
	assign joy      = joy1 | joy2;
	assign m_right  = joy[`MCR_JOY_RIGHT];
	assign m_left   = joy[`MCR_JOY_LEFT];
	assign m_down   = joy[`MCR_JOY_DOWN];
	assign m_up     = joy[`MCR_JOY_UP];
	assign m_fire_a = joy[`MCR_JOY_FIRE_A];
	assign m_fire_b = joy[`MCR_JOY_FIRE_B];
	assign m_fire_c = joy[`MCR_JOY_FIRE_C];
	assign m_fire_d = joy[`MCR_JOY_FIRE_D];
	assign m_start1 = joy[`MCR_JOY_START1];
	assign m_start2 = joy[`MCR_JOY_START2];

	// Discs of Tron has no coin button of its own on the pad, start counts too
	assign m_coin = joy[`MCR_JOY_COIN] |
		((game == game_pkg::DOTRON) & (m_start1 | m_start2));

	// ============================================================
	// Spinner selection
	// ============================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sp1_q  <= '0;
			sp2_q  <= '0;
			sp_sel <= 1'b0;
			spin   <= '0;
		end else begin
			sp1_q <= sp1;
			sp2_q <= sp2;
			// Spinner 2 wins when both move together
			if (sp1_q != sp1)
				sp_sel <= 1'b0;
			if (sp2_q != sp2)
				sp_sel <= 1'b1;
			spin <= sp_sel ? sp2 : sp1;
		end
	end

	// ============================================================
	// Per-game input bytes
	// ============================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			input_0   <= '1;
			input_1   <= '1;
			input_2   <= '1;
			input_3   <= '1;
			input_4   <= '1;
			landscape <= 1'b1;
		end else begin
			input_3   <= dip0;
			input_4   <= '1;
			landscape <= (game != game_pkg::JOURNEY);
			case (game)
				game_pkg::TAPPER: begin
					input_0 <= ~{service, 3'b000, m_start2, m_start1, 1'b0, m_coin};
					input_1 <= ~{3'b000, m_fire_a, m_up, m_down, m_left, m_right};
					input_2 <= ~{3'b000, m_fire_a, m_up, m_down, m_left, m_right};
				end
				game_pkg::TIMBER: begin
					input_0 <= ~{service, 3'b000, m_start2, m_start1, 1'b0, m_coin};
					input_1 <= ~{2'b00, joy1[`MCR_JOY_FIRE_A], joy1[`MCR_JOY_FIRE_B],
						joy1[`MCR_JOY_UP], joy1[`MCR_JOY_DOWN],
						joy1[`MCR_JOY_LEFT], joy1[`MCR_JOY_RIGHT]};
					input_2 <= ~{2'b00, joy2[`MCR_JOY_FIRE_A], joy2[`MCR_JOY_FIRE_B],
						joy2[`MCR_JOY_UP], joy2[`MCR_JOY_DOWN],
						joy2[`MCR_JOY_LEFT], joy2[`MCR_JOY_RIGHT]};
				end
				game_pkg::DOTRON: begin
					input_0 <= ~{service, 2'b00, m_fire_a, m_start2, m_start1, 1'b0, m_coin};
					input_1 <= ~{1'b0, spin[7:1]};
					input_2 <= ~{1'b0, m_fire_b, m_fire_c, m_fire_d, m_down, m_up, m_right, m_left};
				end
				default: begin
					input_0 <= ~{service, 2'b00, m_fire_a, m_start2, m_start1, 1'b0, m_coin};
					input_1 <= ~{4'b0000, m_down, m_up, m_right, m_left};
					input_2 <= ~{3'b000, m_fire_a, m_down, m_up, m_right, m_left};
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/mcr3_frontend.sv
// MCR-3 board frontend
// Loader, input mapping, wave fetch and Journey mixing around the core

`timescale 1ns/100ps
`default_nettype none

module mcr3_frontend (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// Host loader
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  game_pkg::dl_index_t   ioctl_index,
	input  game_pkg::dl_addr_t    ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  status_reset,
	input  logic                  button_reset,
	output logic                  rom_wr,
	output logic                  rom_loaded,
	output logic                  wav_loaded,
	output logic                  core_reset,
	output game_pkg::game_t       game,
	// Player controls
	input  game_pkg::joy_word_t   joy1,
	input  game_pkg::joy_word_t   joy2,
	input  game_pkg::spin_pos_t   sp1,
	input  game_pkg::spin_pos_t   sp2,
	output game_pkg::input_byte_t input_0,
	output game_pkg::input_byte_t input_1,
	output game_pkg::input_byte_t input_2,
	output game_pkg::input_byte_t input_3,
	output game_pkg::input_byte_t input_4,
	output logic                  landscape,
	// Wave player and its memory
	input  logic                  wav_rd,
	input  logic [2:0]            wav_addr_lo,
	input  audio_pkg::mem_word_t  mem_data,
	input  logic                  mem_ack,
	input  logic [7:0]            cpu_output4,
	output logic                  mem_rd,
	output logic                  wav_ready,
	output logic [7:0]            wav_data,
	output logic                  wave_pause,
	output logic                  player_reset,
	// Audio
	input  audio_pkg::sample_t    core_audio_l,
	input  audio_pkg::sample_t    core_audio_r,
	input  audio_pkg::sample_t    pcm,
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r,
	output logic                  audio_signed
);

	game_pkg::input_byte_t dip0;
	logic                  service;

	download_ctrl u_download_ctrl (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.rom_wr         (rom_wr),
		.rom_loaded     (rom_loaded),
		.wav_loaded     (wav_loaded),
		.core_reset     (core_reset),
		.game           (game),
		.dip0           (dip0),
		.service        (service)
	);

	input_mapper u_input_mapper (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.joy1      (joy1),
		.joy2      (joy2),
		.sp1       (sp1),
		.sp2       (sp2),
		.game      (game),
		.dip0      (dip0),
		.service   (service),
		.input_0   (input_0),
		.input_1   (input_1),
		.input_2   (input_2),
		.input_3   (input_3),
		.input_4   (input_4),
		.landscape (landscape)
	);

	wave_fetch u_wave_fetch (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.core_reset   (core_reset),
		.wav_loaded   (wav_loaded),
		.wav_rd       (wav_rd),
		.wav_addr_lo  (wav_addr_lo),
		.mem_data     (mem_data),
		.mem_ack      (mem_ack),
		.cpu_output4  (cpu_output4),
		.mem_rd       (mem_rd),
		.wav_ready    (wav_ready),
		.wav_data     (wav_data),
		.wave_pause   (wave_pause),
		.player_reset (player_reset)
	);

	audio_mixer u_audio_mixer (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.game         (game),
		.core_audio_l (core_audio_l),
		.core_audio_r (core_audio_r),
		.pcm          (pcm),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_signed (audio_signed)
	);

endmodule

`default_nettype wire

//--- logic/mcr3_frontend_params.svh
// MCR-3 frontend constants
// Loader indexes, download limits, reset hold and joystick bit positions

`ifndef MCR3_FRONTEND_PARAMS_SVH
`define MCR3_FRONTEND_PARAMS_SVH

// Host loader indexes
`define MCR_DL_ROM        8'd0
`define MCR_DL_GAME       8'd1
`define MCR_DL_WAV        8'd2
`define MCR_DL_DIP        8'd254

`define MCR_DIP_BANKS     8
`define MCR_CPU_ROM_LIMIT 25'h001_0000
`define MCR_RESET_HOLD    16'hffff

// Bit positions inside a joystick word
`define MCR_JOY_RIGHT     0
`define MCR_JOY_LEFT      1
`define MCR_JOY_DOWN      2
`define MCR_JOY_UP        3
`define MCR_JOY_FIRE_A    4
`define MCR_JOY_FIRE_B    5
`define MCR_JOY_FIRE_C    6
`define MCR_JOY_FIRE_D    7
`define MCR_JOY_START1    10
`define MCR_JOY_START2    11
`define MCR_JOY_COIN      12

`endif

//--- logic/wave_fetch.sv
// Wave fetch
// Converts sample player read requests into memory request toggles,
// raises ready on acknowledge and picks the addressed byte

`timescale 1ns/100ps
`default_nettype none

module wave_fetch (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  core_reset,
	input  logic                  wav_loaded,
	input  logic                  wav_rd,
	input  logic [2:0]            wav_addr_lo,
	input  audio_pkg::mem_word_t  mem_data,
	input  logic                  mem_ack,
	input  logic [7:0]            cpu_output4,
	output logic                  mem_rd,
	output logic                  wav_ready,
	output logic [7:0]            wav_data,
	output logic                  wave_pause,
	output logic                  player_reset
);

	logic wav_rd_q;
	logic mem_ack_q;
	logic rd_rise;

	assign rd_rise = wav_rd & ~wav_rd_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wav_rd_q   <= 1'b0;
			mem_ack_q  <= 1'b0;
			mem_rd     <= 1'b0;
			wav_ready  <= 1'b0;
			wave_pause <= 1'b0;
		end else begin
			wav_rd_q  <= wav_rd;
			mem_ack_q <= mem_ack;

			if ((mem_ack_q ^ mem_ack) | core_reset)
				wav_ready <= 1'b1;

			// A new request overrides a same-cycle acknowledge
			if (rd_rise) begin
				mem_rd    <= ~mem_rd;
				wav_ready <= 1'b0;
			end

			// CPU output port bit 0 low pauses the player
			wave_pause <= ~cpu_output4[0];
		end
	end

	// Byte lane of the 64-bit memory word
	assign wav_data = mem_data[{wav_addr_lo, 3'b000} +: 8];

	assign player_reset = core_reset | ~wav_loaded;

endmodule

`default_nettype wire

//--- mcr3_frontend.f
+incdir+logic
logic/game_pkg.sv
logic/audio_pkg.sv
logic/download_ctrl.sv
logic/input_mapper.sv
logic/wave_fetch.sv
logic/audio_mixer.sv
logic/mcr3_frontend.sv
verification/mcr3_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the MCR-3 frontend testbench with Verilator and run it.
# Exits non-zero unless the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mcr3_frontend_tb -f mcr3_frontend.f -o mcr3_frontend_sim || exit 1

sim_out=$(./obj_dir/mcr3_frontend_sim)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED" && echo "simulation ok" ||
	{ echo "simulation reported failure"; exit 1; }

//--- verification/mcr3_frontend_tb.sv
// MCR-3 frontend testbench
// Runs loader, input mapping, spinner, wave fetch and audio mixing checks
// against the top level

`timescale 1ns/100ps
`default_nettype none

`include "mcr3_frontend_params.svh"

module mcr3_frontend_tb;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 ioctl_download;
	logic                 ioctl_wr;
	logic [7:0]           ioctl_index;
	logic [24:0]          ioctl_addr;
	logic [7:0]           ioctl_dout;
	logic                 status_reset;
	logic                 button_reset;
	logic                 rom_wr;
	logic                 rom_loaded;
	logic                 wav_loaded;
	logic                 core_reset;
	game_pkg::game_t      game;
	logic [31:0]          joy1;
	logic [31:0]          joy2;
	logic [8:0]           sp1;
	logic [8:0]           sp2;
	logic [7:0]           input_0;
	logic [7:0]           input_1;
	logic [7:0]           input_2;
	logic [7:0]           input_3;
	logic [7:0]           input_4;
	logic                 landscape;
	logic                 wav_rd;
	logic [2:0]           wav_addr_lo;
	logic [63:0]          mem_data;
	logic                 mem_ack;
	logic [7:0]           cpu_output4;
	logic                 mem_rd;
	logic                 wav_ready;
	logic [7:0]           wav_data;
	logic                 wave_pause;
	logic                 player_reset;
	logic [15:0]          core_audio_l;
	logic [15:0]          core_audio_r;
	logic [15:0]          pcm;
	logic [15:0]          audio_l;
	logic [15:0]          audio_r;
	logic                 audio_signed;

	integer      seed;
	integer      checks;
	integer      failures;
	integer      test_errors;
	integer      tests_done;
	string       test_name;
	integer      n;
	integer      i;
	integer      g;
	logic        svc;
	logic        prev_rd;
	logic        stuck;
	logic [8:0]  spin_now;
	logic [23:0] exp_in;
	logic [63:0] lane;

	mcr3_frontend u_mcr3_frontend (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Concurrent checks
	// ============================================================

	input4_ones: assert property (@(posedge clk_sys) disable iff (!rst_n) input_4 == 8'hff)
	else begin
		failures = failures + 1;
		$display("FAIL %s input_4: expected ff actual %0h", test_name, input_4);
	end

	rom_wr_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_wr |-> (ioctl_index == `MCR_DL_ROM && ioctl_addr < `MCR_CPU_ROM_LIMIT))
	else begin
		failures = failures + 1;
		$display("ERROR %s: rom_wr high outside the CPU ROM range, addr %0h",
			test_name, ioctl_addr);
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic advance_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic note_error(input string what);
		failures    = failures + 1;
		test_errors = test_errors + 1;
		$display("ERROR %s: %s", test_name, what);
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks = checks + 1;
		assert (actual === expected)
		else begin
			failures    = failures + 1;
			test_errors = test_errors + 1;
			$display("FAIL %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_done = tests_done + 1;
		$display("test %s done, %0d mismatches", test_name, test_errors);
	endtask

	// One loader byte with rom_wr checked against index and address during the strobe
	task automatic loader_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		#1;
		check_value("rom_wr", ioctl_download && index == `MCR_DL_ROM &&
			addr < `MCR_CPU_ROM_LIMIT, rom_wr);
		advance_cycle();
		ioctl_wr = 1'b0;
	endtask

	// Game byte takes two cycles and the input bytes one more
	task automatic select_game(input logic [7:0] game_byte);
		ioctl_download = 1'b1;
		loader_write(`MCR_DL_GAME, 25'd0, game_byte);
		ioctl_download = 1'b0;
		advance_cycle();
		advance_cycle();
	endtask

	task automatic write_dip(input logic [24:0] bank, input logic [7:0] value);
		ioctl_download = 1'b1;
		loader_write(`MCR_DL_DIP, bank, value);
		ioctl_download = 1'b0;
	endtask

	// Active-low cabinet layouts packed as {input_0, input_1, input_2}
	function automatic logic [23:0] expected_inputs(input logic [1:0] gm,
		input logic [31:0] j1, input logic [31:0] j2, input logic svc_bit,
		input logic [8:0] sp);
		logic [31:0] m;
		logic        coin;
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic [7:0]  b2;
		m    = j1 | j2;
		coin = m[`MCR_JOY_COIN];
		if (gm == game_pkg::DOTRON)
			coin = coin | m[`MCR_JOY_START1] | m[`MCR_JOY_START2];
		b0 = {svc_bit, 3'b000, m[`MCR_JOY_START2], m[`MCR_JOY_START1], 1'b0, coin};
		if (gm == game_pkg::DOTRON || gm == game_pkg::JOURNEY)
			b0[4] = m[`MCR_JOY_FIRE_A];
		case (gm)
			game_pkg::TAPPER: begin
				b1 = {3'b000, m[`MCR_JOY_FIRE_A], m[`MCR_JOY_UP], m[`MCR_JOY_DOWN],
					m[`MCR_JOY_LEFT], m[`MCR_JOY_RIGHT]};
				b2 = b1;
			end
			game_pkg::TIMBER: begin
				b1 = {2'b00, j1[`MCR_JOY_FIRE_A], j1[`MCR_JOY_FIRE_B], j1[`MCR_JOY_UP],
					j1[`MCR_JOY_DOWN], j1[`MCR_JOY_LEFT], j1[`MCR_JOY_RIGHT]};
				b2 = {2'b00, j2[`MCR_JOY_FIRE_A], j2[`MCR_JOY_FIRE_B], j2[`MCR_JOY_UP],
					j2[`MCR_JOY_DOWN], j2[`MCR_JOY_LEFT], j2[`MCR_JOY_RIGHT]};
			end
			game_pkg::DOTRON: begin
				b1 = {1'b0, sp[7:1]};
				b2 = {1'b0, m[`MCR_JOY_FIRE_B], m[`MCR_JOY_FIRE_C], m[`MCR_JOY_FIRE_D],
					m[`MCR_JOY_DOWN], m[`MCR_JOY_UP], m[`MCR_JOY_RIGHT], m[`MCR_JOY_LEFT]};
			end
			default: begin
				b1 = {4'b0000, m[`MCR_JOY_DOWN], m[`MCR_JOY_UP], m[`MCR_JOY_RIGHT],
					m[`MCR_JOY_LEFT]};
				b2 = {3'b000, m[`MCR_JOY_FIRE_A], m[`MCR_JOY_DOWN], m[`MCR_JOY_UP],
					m[`MCR_JOY_RIGHT], m[`MCR_JOY_LEFT]};
			end
		endcase
		return ~{b0, b1, b2};
	endfunction

	// Journey mix of halved signed PCM and unsigned core sample with clamping
	function automatic logic [15:0] expected_mix(input logic [15:0] p, input logic [15:0] core);
		integer half;
		integer sum;
		half = {{16{p[15]}}, p};
		half = half >>> 1;
		sum  = half + {16'd0, core};
		// The sum is held in 17 signed bits before clamping
		sum  = {{15{sum[16]}}, sum[16:0]};
		if (sum > 32767)
			return 16'h7fff;
		else if (sum < -32768)
			return 16'h8000;
		return sum[15:0];
	endfunction

	// Spinner byte may lag a move by up to three cycles
	task automatic wait_spin(input string what);
		integer      count;
		logic [23:0] expected;
		expected = expected_inputs(game_pkg::DOTRON, joy1, joy2, svc, spin_now);
		count    = 0;
		while (input_1 !== expected[15:8] && count < 6) begin
			advance_cycle();
			count = count + 1;
		end
		check_value(what, expected[15:8], input_1);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		seed           = 32'he50c_c1dc;
		checks         = 0;
		failures       = 0;
		test_errors    = 0;
		tests_done     = 0;
		test_name      = "reset";
		svc            = 1'b0;
		spin_now       = 9'd0;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = 25'd0;
		ioctl_dout     = 8'd0;
		status_reset   = 1'b0;
		button_reset   = 1'b0;
		joy1           = 32'd0;
		joy2           = 32'd0;
		sp1            = 9'd0;
		sp2            = 9'd0;
		wav_rd         = 1'b0;
		wav_addr_lo    = 3'd0;
		mem_data       = 64'd0;
		mem_ack        = 1'b0;
		cpu_output4    = 8'd0;
		core_audio_l   = 16'd0;
		core_audio_r   = 16'd0;
		pcm            = 16'd0;
		repeat (10) @(posedge clk_sys);
		#10;
		rst_n = 1'b1;
		advance_cycle();

		begin_test("rom_load");
		check_value("core_reset after reset", 1'b1, core_reset);
		check_value("rom_loaded after reset", 1'b0, rom_loaded);
		ioctl_download = 1'b1;
		// Addresses step by 16K so that half of them lie above the CPU ROM
		for (i = 0; i < 8; i = i + 1)
			loader_write(`MCR_DL_ROM, {i[10:0], 14'd0}, $random(seed));
		loader_write(`MCR_DL_ROM, 25'h000_ffff, 8'ha5);
		check_value("core_reset during download", 1'b1, core_reset);
		ioctl_download = 1'b0;
		n = 0;
		while (!rom_loaded && n < 10) begin
			advance_cycle();
			n = n + 1;
		end
		assert (rom_loaded) else note_error("rom_loaded did not rise after the ROM download");
		n = 0;
		while (core_reset && n < 10) begin
			advance_cycle();
			n = n + 1;
		end
		assert (!core_reset) else note_error("core_reset did not fall after the ROM load");
		n = 0;
		while (!core_reset && n < 70000) begin
			advance_cycle();
			n = n + 1;
		end
		assert (core_reset) else note_error("no delayed core_reset pulse within 70000 cycles");
		assert (n > 65000) else note_error("delayed core_reset pulse came too early");
		advance_cycle();
		check_value("core_reset pulse width", 1'b0, core_reset);
		stuck = 1'b0;
		for (i = 0; i < 200; i = i + 1) begin
			advance_cycle();
			if (core_reset)
				stuck = 1'b1;
		end
		check_value("core_reset after pulse", 1'b0, stuck);
		finish_test();

		begin_test("game_dip");
		write_dip(25'd0, 8'h5a);
		write_dip(25'd1, 8'h01);
		// Bank 8 is out of range and must not alias bank 0
		write_dip(25'd8, 8'hff);
		select_game(8'd0);
		check_value("input_3", 8'h5a, input_3);
		check_value("service bit set", 1'b0, input_0[7]);
		write_dip(25'd1, 8'h00);
		advance_cycle();
		check_value("service bit clear", 1'b1, input_0[7]);
		for (g = 0; g < 5; g = g + 1) begin
			select_game((g == 4) ? 8'd7 : g[7:0]);
			check_value("game", (g == 4) ? 0 : g, game);
			check_value("landscape", g != 3, landscape);
		end
		finish_test();

		begin_test("input_map");
		for (g = 0; g < 4; g = g + 1) begin
			select_game(g[7:0]);
			for (i = 0; i < 12; i = i + 1) begin
				if (i == 0) begin
					joy1 = 32'd1 << `MCR_JOY_START1;
					joy2 = 32'd0;
				end else begin
					joy1 = $random(seed);
					joy2 = $random(seed);
				end
				advance_cycle();
				advance_cycle();
				exp_in = expected_inputs(g[1:0], joy1, joy2, svc, spin_now);
				check_value("input_0", exp_in[23:16], input_0);
				check_value("input_1", exp_in[15:8], input_1);
				check_value("input_2", exp_in[7:0], input_2);
				check_value("input_3", 8'h5a, input_3);
			end
		end
		finish_test();

		begin_test("spinner");
		joy1 = 32'd0;
		joy2 = 32'd0;
		select_game(8'd2);
		sp2      = 9'h0b4;
		spin_now = sp2;
		wait_spin("input_1 after sp2 move");
		sp1      = 9'h14b;
		spin_now = sp1;
		wait_spin("input_1 after sp1 move");
		// Spinner 2 takes priority when both move together
		sp1      = 9'h066;
		sp2      = 9'h1d9;
		spin_now = sp2;
		wait_spin("input_1 after both move");
		finish_test();

		begin_test("wave_fetch");
		check_value("player_reset before wave load", 1'b1, player_reset);
		check_value("wav_ready idle", 1'b1, wav_ready);
		ioctl_download = 1'b1;
		loader_write(`MCR_DL_WAV, 25'd0, 8'h52);
		loader_write(`MCR_DL_WAV, 25'd1, 8'h49);
		ioctl_download = 1'b0;
		n = 0;
		while (!wav_loaded && n < 10) begin
			advance_cycle();
			n = n + 1;
		end
		assert (wav_loaded) else note_error("wav_loaded did not rise after the wave download");
		check_value("player_reset after wave load", 1'b0, player_reset);
		for (i = 0; i < 8; i = i + 1) begin
			prev_rd     = mem_rd;
			mem_data    = {$random(seed), $random(seed)};
			wav_addr_lo = i[2:0];
			wav_rd      = 1'b1;
			#1;
			lane = mem_data >> (8 * i);
			check_value("wav_data", lane[7:0], wav_data);
			advance_cycle();
			check_value("mem_rd toggle", !prev_rd, mem_rd);
			check_value("wav_ready on request", 1'b0, wav_ready);
			wav_rd = 1'b0;
			advance_cycle();
			check_value("wav_ready before ack", 1'b0, wav_ready);
			mem_ack = ~mem_ack;
			n = 0;
			while (!wav_ready && n < 8) begin
				advance_cycle();
				n = n + 1;
			end
			assert (wav_ready) else note_error("wav_ready did not rise after mem_ack toggled");
		end
		for (i = 0; i < 6; i = i + 1) begin
			cpu_output4 = $random(seed);
			advance_cycle();
			check_value("wave_pause", !cpu_output4[0], wave_pause);
		end
		finish_test();

		begin_test("audio_mix");
		select_game(8'd3);
		for (i = 0; i < 20; i = i + 1) begin
			case (i)
				0: begin
					pcm          = 16'h8000;
					core_audio_l = 16'hffff;
					core_audio_r = 16'h0000;
				end
				1: begin
					pcm          = 16'h7fff;
					core_audio_l = 16'hffff;
					core_audio_r = 16'h8000;
				end
				2: begin
					pcm          = 16'hffff;
					core_audio_l = 16'h0000;
					core_audio_r = 16'h0001;
				end
				3: begin
					pcm          = 16'h0001;
					core_audio_l = 16'h7fff;
					core_audio_r = 16'h8000;
				end
				default: begin
					pcm          = $random(seed);
					core_audio_l = $random(seed);
					core_audio_r = $random(seed);
				end
			endcase
			advance_cycle();
			check_value("audio_l mix", expected_mix(pcm, core_audio_l), audio_l);
			check_value("audio_r mix", expected_mix(pcm, core_audio_r), audio_r);
			check_value("audio_signed journey", 1'b1, audio_signed);
		end
		select_game(8'd0);
		for (i = 0; i < 6; i = i + 1) begin
			pcm          = $random(seed);
			core_audio_l = $random(seed);
			core_audio_r = $random(seed);
			advance_cycle();
			check_value("audio_l pass", core_audio_l, audio_l);
			check_value("audio_r pass", core_audio_r, audio_r);
			check_value("audio_signed other", 1'b0, audio_signed);
		end
		finish_test();

		$display("tests %0d, checks %0d, failures %0d", tests_done, checks, failures);
		if (failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
